/* common/spi_flash_params.svh */
`ifndef SPI_FLASH_PARAMS_SVH
`define SPI_FLASH_PARAMS_SVH

// Bus and payload widths
`define SPI_DATA_W 32
`define SPI_ADDR_W 24
`define SPI_CMD_W 8

// Opcode + address + write data, sent MSB first
`define SPI_FRAME_W 64
`define SPI_CNT_W 7

`define SPI_CLKS_PER_HALF 2

`endif

/* common/spi_flash_pkg.sv */
`include "spi_flash_params.svh"

package spi_flash_pkg;

    typedef logic [`SPI_DATA_W-1:0] word_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [2:0] adr;
        word_t      dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [`SPI_CMD_W-1:0]  opcode;
        logic                   has_addr;
        logic                   is_read;
        logic [3:0]             dummy;
        logic [5:0]             nbits;
        logic [`SPI_ADDR_W-1:0] addr;
        word_t                  wdata;
    } spi_cmd_t;

    typedef struct packed {
        logic [`SPI_FRAME_W-1:0] txbits;
        logic [`SPI_CNT_W-1:0]   ntx;
        logic [3:0]              ndummy;
        logic [5:0]              nrx;
    } spi_frame_t;

    typedef enum logic [2:0] {
        CTRL   = 3'd0,
        ADDR   = 3'd1,
        WDATA  = 3'd2,
        RDATA  = 3'd3,
        STATUS = 3'd4
    } reg_addr_e;

endpackage

/* spi_master/spi_frame_builder.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_frame_builder (
    input  logic                      clk,
    input  logic                      rst,
    input  spi_flash_pkg::spi_cmd_t   cmd,
    input  logic                      start_build,
    output spi_flash_pkg::spi_frame_t frame
);

    logic [`SPI_DATA_W-1:0]  data_mask;
    logic [`SPI_DATA_W-1:0]  data_bits;
    logic [`SPI_FRAME_W-1:0] txbits;
    logic [`SPI_CNT_W-1:0]   ntx;

    // Top nbits of the write word only
    assign data_mask = ~({`SPI_DATA_W{1'b1}} >> cmd.nbits);
    assign data_bits = cmd.is_read ? '0 : (cmd.wdata & data_mask);

    always_comb begin
        txbits = '0;
        txbits[`SPI_FRAME_W-1 -: `SPI_CMD_W] = cmd.opcode;
        if (cmd.has_addr) begin
            txbits[`SPI_FRAME_W-`SPI_CMD_W-1 -: `SPI_ADDR_W] = cmd.addr;
            txbits[`SPI_DATA_W-1:0] = data_bits;
        end else begin
            txbits[`SPI_FRAME_W-`SPI_CMD_W-1 -: `SPI_DATA_W] = data_bits;
        end
    end

    assign ntx = `SPI_CNT_W'(`SPI_CMD_W)
               + (cmd.has_addr ? `SPI_CNT_W'(`SPI_ADDR_W) : `SPI_CNT_W'(0))
               + (cmd.is_read ? `SPI_CNT_W'(0) : `SPI_CNT_W'(cmd.nbits));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame <= '0;
        end else if (start_build) begin
            frame.txbits <= txbits;
            frame.ntx    <= ntx;
            frame.ndummy <= cmd.dummy;
            frame.nrx    <= cmd.is_read ? cmd.nbits : 6'd0;
        end
    end

endmodule

/* spi_master/spi_sclk_gen.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_sclk_gen #(
    parameter int CLKS_PER_HALF = `SPI_CLKS_PER_HALF,
    parameter bit CPOL          = 1'b0,
    parameter bit CPHA          = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic sclk_en,
    output logic sclk,
    output logic launch,
    output logic sample
);

    localparam int CNT_W = $clog2(CLKS_PER_HALF + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_HALF - 1);

    logic [CNT_W-1:0] cnt;
    logic             edge_now;
    logic             lead;
    logic             trail;

    // Strobes line up with the edge at which sclk itself toggles
    assign edge_now = sclk_en & (cnt == CNT_MAX);
    assign lead     = edge_now & (sclk == CPOL);
    assign trail    = edge_now & (sclk != CPOL);

    assign launch = CPHA ? lead : trail;
    assign sample = CPHA ? trail : lead;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            sclk <= CPOL;
        end else if (!sclk_en) begin
            cnt  <= '0;
            sclk <= CPOL;
        end else if (edge_now) begin
            cnt  <= '0;
            sclk <= ~sclk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* spi_master/spi_shifter.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_shifter (
    input  logic                      clk,
    input  logic                      rst,
    input  spi_flash_pkg::spi_frame_t frame,
    input  logic                      load,
    input  logic                      launch,
    input  logic                      sample,
    output logic                      mosi,
    input  logic                      miso,
    output spi_flash_pkg::word_t      rdata,
    output logic                      last
);

    logic [`SPI_FRAME_W-1:0] sr;
    logic [`SPI_CNT_W-1:0]   cnt;
    logic [`SPI_CNT_W-1:0]   rx_first;
    logic [`SPI_CNT_W-1:0]   total;

    assign rx_first = frame.ntx + `SPI_CNT_W'(frame.ndummy);
    assign total    = rx_first + `SPI_CNT_W'(frame.nrx);

    // Frame is zero padded, so dummy and read phases see mosi low
    assign mosi = sr[`SPI_FRAME_W-1];
    assign last = sample & (cnt == total - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr    <= '0;
            cnt   <= '0;
            rdata <= '0;
        end else if (load) begin
            sr    <= frame.txbits;
            cnt   <= '0;
            rdata <= '0;
        end else begin
            // First bit already sits on mosi from load, so no shift before a sample
            if (launch && cnt != '0) begin
                sr <= {sr[`SPI_FRAME_W-2:0], 1'b0};
            end
            if (sample) begin
                cnt <= cnt + 1'b1;
                if (cnt >= rx_first) begin
                    rdata <= {rdata[`SPI_DATA_W-2:0], miso};
                end
            end
        end
    end

endmodule

/* spi_master/spi_master_fsm.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_master_fsm #(
    parameter int CLKS_PER_HALF = `SPI_CLKS_PER_HALF,
    parameter bit CPOL          = 1'b0,
    parameter bit CPHA          = 1'b0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  spi_flash_pkg::spi_cmd_t cmd,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    output spi_flash_pkg::word_t    rdata,
    output logic                    sclk,
    output logic                    cs_n,
    output logic                    mosi,
    input  logic                    miso
);

    typedef enum logic [1:0] {IDLE, BUILD, XFER, END} state_e;

    state_e                    state;
    spi_flash_pkg::spi_cmd_t   cmd_q;
    spi_flash_pkg::spi_frame_t frame;
    logic                      start_build;
    logic                      load;
    logic                      sclk_en;
    logic                      launch;
    logic                      sample;
    logic                      last;

    assign start_build = (state == BUILD);
    assign busy        = (state != IDLE);
    assign done        = (state == END);

    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            load    <= 1'b0;
            sclk_en <= 1'b0;
            cs_n    <= 1'b1;
        end else begin
            load <= 1'b0;
            case (state)
                IDLE: if (start) state <= BUILD;
                BUILD: begin
                    // Frame is registered by now, shifter picks it up next cycle
                    load  <= 1'b1;
                    state <= XFER;
                end
                XFER: begin
                    if (load) begin
                        cs_n    <= 1'b0;
                        sclk_en <= 1'b1;
                    end
                    if (last) begin
                        sclk_en <= 1'b0;
                        state   <= END;
                    end
                end
                END: begin
                    cs_n  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    spi_frame_builder builder_i (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd_q),
        .start_build (start_build),
        .frame       (frame)
    );

    spi_sclk_gen #(
        .CLKS_PER_HALF (CLKS_PER_HALF),
        .CPOL          (CPOL),
        .CPHA          (CPHA)
    ) sclk_gen_i (
        .clk     (clk),
        .rst     (rst),
        .sclk_en (sclk_en),
        .sclk    (sclk),
        .launch  (launch),
        .sample  (sample)
    );

    spi_shifter shifter_i (
        .clk    (clk),
        .rst    (rst),
        .frame  (frame),
        .load   (load),
        .launch (launch),
        .sample (sample),
        .mosi   (mosi),
        .miso   (miso),
        .rdata  (rdata),
        .last   (last)
    );

endmodule

/* source/spi_wb_regs.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_wb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  spi_flash_pkg::wb_req_t  wb_req,
    output spi_flash_pkg::wb_rsp_t  wb_rsp,
    output spi_flash_pkg::spi_cmd_t cmd,
    output logic                    start,
    input  logic                    busy,
    input  logic                    done,
    input  spi_flash_pkg::word_t    rdata
);

    logic                      access;
    logic                      ack_q;
    logic [19:0]               ctrl_q;
    logic [`SPI_ADDR_W-1:0]    addr_q;
    spi_flash_pkg::word_t      wdata_q;
    spi_flash_pkg::word_t      rdata_q;
    spi_flash_pkg::word_t      dat_q;
    spi_flash_pkg::word_t      rd_mux;
    spi_flash_pkg::reg_addr_e  sel;

    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign sel    = spi_flash_pkg::reg_addr_e'(wb_req.adr);
    assign start  = access & wb_req.we & (sel == spi_flash_pkg::CTRL) & ~busy;

    // Control fields taken off the bus, the FSM samples them on start
    assign cmd.opcode   = wb_req.dat[7:0];
    assign cmd.has_addr = wb_req.dat[8];
    assign cmd.is_read  = wb_req.dat[9];
    assign cmd.dummy    = wb_req.dat[13:10];
    assign cmd.nbits    = wb_req.dat[19:14];
    assign cmd.addr     = addr_q;
    assign cmd.wdata    = wdata_q;

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

    always_comb begin
        case (sel)
            spi_flash_pkg::CTRL:   rd_mux = {12'b0, ctrl_q};
            spi_flash_pkg::ADDR:   rd_mux = {{(`SPI_DATA_W-`SPI_ADDR_W){1'b0}}, addr_q};
            spi_flash_pkg::WDATA:  rd_mux = wdata_q;
            spi_flash_pkg::RDATA:  rd_mux = rdata_q;
            spi_flash_pkg::STATUS: rd_mux = {{(`SPI_DATA_W-1){1'b0}}, busy};
            default:               rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q   <= 1'b0;
            ctrl_q  <= '0;
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
        end else begin
            ack_q <= access;
            if (access && wb_req.we) begin
                case (sel)
                    // Ignored while a frame is running
                    spi_flash_pkg::CTRL:  if (!busy) ctrl_q <= wb_req.dat[19:0];
                    spi_flash_pkg::ADDR:  addr_q <= wb_req.dat[`SPI_ADDR_W-1:0];
                    spi_flash_pkg::WDATA: wdata_q <= wb_req.dat;
                    default: ;
                endcase
            end
            if (done) begin
                rdata_q <= rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_q <= rd_mux;
        end
    end

endmodule

/* source/spi_flash_ctrl.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_flash_ctrl #(
    parameter int CLKS_PER_HALF = `SPI_CLKS_PER_HALF,
    parameter bit CPOL          = 1'b0,
    parameter bit CPHA          = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  spi_flash_pkg::wb_req_t wb_req,
    output spi_flash_pkg::wb_rsp_t wb_rsp,
    output logic                   sclk,
    output logic                   cs_n,
    output logic                   mosi,
    input  logic                   miso
);

    spi_flash_pkg::spi_cmd_t cmd;
    spi_flash_pkg::word_t    rdata;
    logic                    start;
    logic                    busy;
    logic                    done;

    spi_wb_regs regs_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cmd    (cmd),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .rdata  (rdata)
    );

    spi_master_fsm #(
        .CLKS_PER_HALF (CLKS_PER_HALF),
        .CPOL          (CPOL),
        .CPHA          (CPHA)
    ) master_i (
        .clk   (clk),
        .rst   (rst),
        .cmd   (cmd),
        .start (start),
        .busy  (busy),
        .done  (done),
        .rdata (rdata),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .mosi  (mosi),
        .miso  (miso)
    );

endmodule

/* bench/spi_flash_model.sv */
`timescale 1ns/1ps

module spi_flash_model (
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    localparam logic [23:0] JEDEC_ID = 24'hEF4018;

    // MOSI bits of the current frame, first bit at the top
    logic [127:0] bits = '0;
    int           nbits = 0;
    int           frames = 0;
    int           started = 0;
    logic [7:0]   opcode = '0;
    logic [23:0]  addr = '0;
    logic         miso_q = 1'b0;

    assign miso = miso_q;

    // Response bit for wire position n
    function automatic logic next_bit(input int n);
        int         idx;
        logic [7:0] data;
        idx = 0;
        if (opcode == 8'h9F) begin
            return (n >= 8 && n < 32) ? JEDEC_ID[5'(31 - n)] : 1'b0;
        end
        if (opcode == 8'h03 && n >= 32) begin
            idx = n - 32;
        end else if (opcode == 8'h0B && n >= 40) begin
            idx = n - 40;
        end else begin
            return 1'b0;
        end
        data = 8'(addr[7:0] + 8'(idx / 8)) ^ 8'h5A;
        return data[3'(7 - (idx % 8))];
    endfunction

    always @(negedge cs_n) begin
        frames = frames + 1;
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            if (started != frames) begin
                started = frames;
                nbits   = 0;
                bits    = '0;
            end
            if (nbits < 128) begin
                bits[7'(127 - nbits)] = mosi;
            end
            if (nbits < 8) begin
                opcode = {opcode[6:0], mosi};
            end else if (nbits < 32) begin
                addr = {addr[22:0], mosi};
            end
            nbits = nbits + 1;
        end
    end

    // Mode 0: the flash changes miso on the falling edge
    always @(negedge sclk) begin
        if (!cs_n) begin
            miso_q = next_bit(nbits);
        end
    end

endmodule

/* bench/spi_flash_ctrl_chk.sv */
`timescale 1ns/1ps

module spi_flash_ctrl_chk #(
    parameter bit CPOL = 1'b0
) (
    input logic                   clk,
    input logic                   rst,
    input spi_flash_pkg::wb_req_t wb_req,
    input spi_flash_pkg::wb_rsp_t wb_rsp,
    input logic                   sclk,
    input logic                   cs_n
);

    int fail_count = 0;

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            $error("ack raised without cyc and stb");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack held for two cycles");
            fail_count++;
        end

    sclk_parked: assert property (@(posedge clk) disable iff (rst)
        cs_n |-> (sclk == CPOL))
        else begin
            $error("sclk toggles while cs_n is high");
            fail_count++;
        end

    // The edge that acknowledges a CTRL write never moves cs_n
    cs_n_quiet: assert property (@(posedge clk) disable iff (rst)
        (wb_req.cyc && wb_req.stb && wb_req.we && !wb_rsp.ack
            && wb_req.adr == spi_flash_pkg::CTRL) |=> $stable(cs_n))
        else begin
            $error("cs_n changed while a CTRL write was acknowledged");
            fail_count++;
        end

endmodule

/* bench/spi_flash_ctrl_tb.sv */
`timescale 1ns/1ps
`include "spi_flash_params.svh"

module spi_flash_ctrl_tb;

    localparam bit CPOL        = 1'b0;
    localparam bit CPHA        = 1'b0;
    localparam int N_XFERS     = 23;
    localparam int XFER_CYCLES = 79 * 2 * `SPI_CLKS_PER_HALF + 20;
    localparam int WATCHDOG_NS = N_XFERS * XFER_CYCLES * 100 * 2;

    logic                   clk;
    logic                   rst;
    spi_flash_pkg::wb_req_t wb_req;
    spi_flash_pkg::wb_rsp_t wb_rsp;
    logic                   sclk;
    logic                   cs_n;
    logic                   mosi;
    logic                   miso;

    int value_errors = 0;
    int other_errors = 0;
    int pushed = 0;
    int compared = 0;

    // Finished transfers waiting for the compare process
    spi_flash_pkg::spi_cmd_t   sent_q[$];
    spi_flash_pkg::word_t      got_q[$];
    spi_flash_pkg::spi_frame_t wire_q[$];
    string                     name_q[$];

    spi_flash_ctrl #(
        .CPOL (CPOL),
        .CPHA (CPHA)
    ) dut_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .miso   (miso)
    );

    spi_flash_model flash_i (
        .sclk (sclk),
        .cs_n (cs_n),
        .mosi (mosi),
        .miso (miso)
    );

    bind spi_flash_ctrl spi_flash_ctrl_chk #(.CPOL(CPOL)) chk_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .sclk   (sclk),
        .cs_n   (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transfers did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    function automatic spi_flash_pkg::spi_cmd_t make_cmd(input logic [7:0] opcode,
            input logic has_addr, input logic is_read, input logic [3:0] dummy,
            input logic [5:0] nbits, input logic [23:0] addr, input spi_flash_pkg::word_t wdata);
        spi_flash_pkg::spi_cmd_t cmd;
        cmd.opcode   = opcode;
        cmd.has_addr = has_addr;
        cmd.is_read  = is_read;
        cmd.dummy    = dummy;
        cmd.nbits    = nbits;
        cmd.addr     = addr;
        cmd.wdata    = wdata;
        return cmd;
    endfunction

    function automatic spi_flash_pkg::word_t ctrl_word(input spi_flash_pkg::spi_cmd_t cmd);
        return {12'h000, cmd.nbits, cmd.dummy, cmd.is_read, cmd.has_addr, cmd.opcode};
    endfunction

    // Expected wire view (bit string, total SCLK cycles) and RDATA
    function automatic void ref_frame(input spi_flash_pkg::spi_cmd_t cmd,
            output spi_flash_pkg::spi_frame_t frame, output spi_flash_pkg::word_t rdata);
        int                   pos;
        int                   total;
        spi_flash_pkg::word_t data;
        logic [31:0]          stream;
        frame = '0;
        frame.txbits = {cmd.opcode, 56'h0};
        pos = 8;
        if (cmd.has_addr) begin
            frame.txbits = frame.txbits | {8'h00, cmd.addr, 32'h0};
            pos = 32;
        end
        total = pos + int'(cmd.nbits);
        if (cmd.is_read) begin
            total = total + int'(cmd.dummy);
        end else begin
            data = cmd.wdata >> (32 - int'(cmd.nbits));
            frame.txbits = frame.txbits | ({32'h0, data} << (64 - pos - int'(cmd.nbits)));
        end
        frame.ntx = 7'(total);
        stream = '0;
        if (cmd.opcode == 8'h9F) begin
            stream = {24'hEF4018, 8'h00};
        end else if (cmd.opcode == 8'h03 || cmd.opcode == 8'h0B) begin
            for (int k = 0; k < 4; k++) begin
                stream = {stream[23:0], 8'(cmd.addr[7:0] + 8'(k)) ^ 8'h5A};
            end
        end
        rdata = (cmd.is_read && cmd.nbits != 0) ? stream >> (32 - int'(cmd.nbits)) : '0;
    endfunction

    task automatic check_word(input string name, input spi_flash_pkg::word_t expected,
            input spi_flash_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_frame(input string name, input spi_flash_pkg::spi_frame_t expected,
            input spi_flash_pkg::spi_frame_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h (%0d bits), actual %h (%0d bits)", name,
                     expected.txbits, expected.ntx, actual.txbits, actual.ntx);
            value_errors++;
        end
    endtask

    task automatic wb_access(input logic we, input spi_flash_pkg::reg_addr_e adr,
            input spi_flash_pkg::word_t wdat, output spi_flash_pkg::word_t rdat);
        int cycles;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdat;
        @(negedge clk);
        cycles = 0;
        while (!wb_rsp.ack && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles != 1) begin
            $display("Access to register %0d was acknowledged after %0d cycles instead of one",
                     adr, cycles);
            other_errors++;
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic wb_write(input spi_flash_pkg::reg_addr_e adr, input spi_flash_pkg::word_t dat);
        spi_flash_pkg::word_t unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input spi_flash_pkg::reg_addr_e adr, output spi_flash_pkg::word_t dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    // One transfer; with poke_busy a second CTRL write lands while busy
    task automatic run_cmd(input string name, input spi_flash_pkg::spi_cmd_t cmd,
            input bit poke_busy);
        spi_flash_pkg::word_t      rd;
        spi_flash_pkg::spi_frame_t seen;
        int                        polls;
        int                        frames_before;
        frames_before = flash_i.frames;
        wb_write(spi_flash_pkg::ADDR, {8'h00, cmd.addr});
        wb_write(spi_flash_pkg::WDATA, cmd.wdata);
        wb_write(spi_flash_pkg::CTRL, ctrl_word(cmd));
        if (poke_busy) begin
            wb_write(spi_flash_pkg::CTRL,
                     ctrl_word(make_cmd(8'h9F, 1'b0, 1'b1, 4'd0, 6'd24, 24'h0, '0)));
        end
        polls = 0;
        rd = 32'h1;
        while (rd[0] && polls < 200) begin
            wb_read(spi_flash_pkg::STATUS, rd);
            polls++;
        end
        if (rd[0]) begin
            $display("Transfer %s was still busy after %0d status reads", name, polls);
            other_errors++;
        end
        if (flash_i.frames != frames_before + 1) begin
            $display("Transfer %s put %0d frames on the wire instead of one", name,
                     flash_i.frames - frames_before);
            other_errors++;
        end
        @(negedge clk);
        check_word({name, " cs_n"}, 32'd1, 32'(cs_n));
        wb_read(spi_flash_pkg::RDATA, rd);
        seen = '0;
        seen.txbits = flash_i.bits[127:64];
        seen.ntx = 7'(flash_i.nbits);
        sent_q.push_back(cmd);
        got_q.push_back(rd);
        wire_q.push_back(seen);
        name_q.push_back(name);
        pushed++;
    endtask

    initial begin
        spi_flash_pkg::spi_cmd_t   cmd;
        spi_flash_pkg::spi_frame_t exp_frame;
        spi_flash_pkg::word_t      exp_rdata;
        string                     name;
        forever begin
            wait (compared < pushed);
            cmd = sent_q.pop_front();
            name = name_q.pop_front();
            ref_frame(cmd, exp_frame, exp_rdata);
            check_frame({name, " mosi"}, exp_frame, wire_q.pop_front());
            check_word({name, " rdata"}, exp_rdata, got_q.pop_front());
            compared++;
        end
    end

    initial begin
        spi_flash_pkg::word_t rd;
        spi_flash_pkg::word_t val;
        logic [7:0]           op;
        logic [5:0]           nb;
        void'($urandom(73748));
        wb_req <= '0;
        rst    <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_word("reset cs_n", 32'd1, 32'(cs_n));
        check_word("reset sclk", 32'd0, 32'(sclk));
        check_word("reset mosi", 32'd0, 32'(mosi));
        check_word("reset ack", 32'd0, 32'(wb_rsp.ack));
        wb_read(spi_flash_pkg::STATUS, rd);
        check_word("reset status", 32'd0, rd);

        val = {8'h00, 24'($urandom)};
        wb_write(spi_flash_pkg::ADDR, val);
        wb_read(spi_flash_pkg::ADDR, rd);
        check_word("addr readback", val, rd);
        val = $urandom;
        wb_write(spi_flash_pkg::WDATA, val);
        wb_read(spi_flash_pkg::WDATA, rd);
        check_word("wdata readback", val, rd);

        run_cmd("page program", make_cmd(8'h02, 1'b1, 1'b0, 4'd0, 6'd32,
                24'($urandom), $urandom), 1'b0);

        // Stale WDATA must not reach mosi during reads
        for (int i = 0; i < 20; i++) begin
            op = ($urandom % 2 == 0) ? 8'h03 : 8'h0B;
            nb = 6'((($urandom % 4) + 1) * 8);
            run_cmd($sformatf("read %0d op %h", i, op), make_cmd(op, 1'b1, 1'b1,
                    (op == 8'h0B) ? 4'd8 : 4'd0, nb, 24'($urandom), $urandom), 1'b0);
        end

        run_cmd("read id", make_cmd(8'h9F, 1'b0, 1'b1, 4'd0, 6'd24, 24'h0, $urandom), 1'b0);
        run_cmd("ctrl while busy", make_cmd(8'h03, 1'b1, 1'b1, 4'd0, 6'd16,
                24'($urandom), '0), 1'b1);

        wait (compared == pushed);
        @(posedge clk);
        other_errors += dut_i.chk_i.fail_count;
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* spi_flash_ctrl.f */
+incdir+common
common/spi_flash_pkg.sv
spi_master/spi_frame_builder.sv
spi_master/spi_sclk_gen.sv
spi_master/spi_shifter.sv
spi_master/spi_master_fsm.sv
source/spi_wb_regs.sv
source/spi_flash_ctrl.sv
bench/spi_flash_model.sv
bench/spi_flash_ctrl_chk.sv
bench/spi_flash_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module spi_flash_ctrl_tb \
    -f spi_flash_ctrl.f -o spi_flash_ctrl_sim || exit 1
out=$(./obj_dir/spi_flash_ctrl_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^Testbench passed$" && echo "PASS" || { echo "FAIL"; exit 1; }
